// File: src/huff_cfg.svh
`ifndef HUFF_CFG_SVH
`define HUFF_CFG_SVH

////////////////////////////////////////
// Code table geometry
////////////////////////////////////////

// Symbols 0 to 9, one table entry each
`define HUFF_NUM_SYMBOLS 10
// Longest code, left-justified in its field
`define HUFF_CODE_W 9
// Holds a length of 0 to 9
`define HUFF_LEN_W 4

////////////////////////////////////////
// Message and output buffer
////////////////////////////////////////

// Symbol n of the message is n mod 10
`define HUFF_MSG_LEN 112
// Worst case is 112 x 9 = 1008 bits
`define HUFF_BUF_BITS 1024
`define HUFF_BANK_BITS 64
`define HUFF_NUM_BANKS 16
// Bit count and buffer index, counts up to 1024
`define HUFF_POS_W 11

`endif

// File: src/huff_pkg.sv
`include "huff_cfg.svh"

package huff_pkg;

	////////////////////////////////////////
	// Code table
	////////////////////////////////////////

	// Symbol value, 0 to 9
	typedef logic [$clog2(`HUFF_NUM_SYMBOLS)-1:0] sym_t;

	// Left-justified code, bit 8 goes out first
	typedef logic [`HUFF_CODE_W-1:0] code_bits_t;

	// Number of valid code bits, 0 to 9
	typedef logic [`HUFF_LEN_W-1:0] code_len_t;

	// Code in the upper bits, length in the low nibble
	typedef struct packed {
		code_bits_t code;
		code_len_t  len;
	} code_entry_t;

	// Entry k sits at bits 13k+12 down to 13k
	typedef code_entry_t [`HUFF_NUM_SYMBOLS-1:0] code_table_t;

	////////////////////////////////////////
	// Output buffer
	////////////////////////////////////////

	typedef logic [`HUFF_POS_W-1:0]     bit_pos_t;
	typedef logic [`HUFF_BANK_BITS-1:0] bank_bits_t;

	// Bit i is the i-th packed bit
	typedef logic [`HUFF_BUF_BITS-1:0]  out_buf_t;

	// One write per symbol, broadcast to every bank
	typedef struct packed {
		logic        valid;
		bit_pos_t    pos;
		code_entry_t entry;
	} pack_req_t;

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		EMIT,
		DONE
	} seq_state_e;

endpackage

// File: src/symbol_sequencer.sv
`include "huff_cfg.svh"

module symbol_sequencer
	import huff_pkg::*;
(
	input  logic        CLK,
	input  logic        nRST,
	input  logic        over,
	input  code_table_t code_table,
	output pack_req_t   pack_req,
	output bit_pos_t    count,
	output logic        start
);

	localparam int IDX_W = $clog2(`HUFF_MSG_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`HUFF_MSG_LEN - 1);
	localparam sym_t LAST_SYM = sym_t'(`HUFF_NUM_SYMBOLS - 1);

	seq_state_e       state;
	seq_state_e       state_next;
	logic [IDX_W-1:0] msg_idx;
	sym_t             sym;
	logic             last_sym;
	logic             load_fire;
	logic             emit_fire;

	code_entry_t      entry_q;
	logic             req_valid;
	bit_pos_t         req_pos;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	assign last_sym  = (msg_idx == LAST_IDX);
	assign load_fire = (state == LOAD) && over;
	assign emit_fire = (state == EMIT) && over;

	// Every step waits for over, DONE holds until reset
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (over)
					state_next = LOAD;
			end
			LOAD: begin
				if (over)
					state_next = EMIT;
			end
			EMIT: begin
				if (over)
					state_next = last_sym ? DONE : LOAD;
			end
			DONE: begin
				state_next = DONE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Message position and the matching symbol
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			msg_idx <= '0;
			sym     <= '0;
		end else if (emit_fire && !last_sym) begin
			msg_idx <= msg_idx + 1'b1;
			if (sym == LAST_SYM)
				sym <= '0;
			else
				sym <= sym + 1'b1;
		end
	end

	////////////////////////////////////////
	// Lookup and write request
	////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (load_fire)
			entry_q <= code_table[sym];
	end

	// Write position is the count before this symbol
	always_ff @(posedge CLK) begin
		if (emit_fire)
			req_pos <= count;
	end

	// One-cycle strobe after each EMIT
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			req_valid <= 1'b0;
		end else begin
			req_valid <= emit_fire;
		end
	end

	// entry_q only reloads on the edge where the banks take the request
	assign pack_req = '{valid: req_valid, pos: req_pos, entry: entry_q};

	////////////////////////////////////////
	// Bit count and done flag
	////////////////////////////////////////

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			count <= '0;
		end else if (emit_fire) begin
			count <= count + bit_pos_t'(entry_q.len);
		end
	end

	// Rises together with the last bank write
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			start <= 1'b0;
		end else if (state == DONE) begin
			start <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Request sits in the step after EMIT and still holds the entry it counted
	a_valid_after_emit: assert property (
		@(posedge CLK) disable iff (!nRST)
		pack_req.valid |-> (state == LOAD || state == DONE) &&
			(count == pack_req.pos + bit_pos_t'(pack_req.entry.len))
	);

	a_count_in_buffer: assert property (
		@(posedge CLK) disable iff (!nRST)
		count <= bit_pos_t'(`HUFF_BUF_BITS)
	);

endmodule

// File: src/bit_bank.sv
`include "huff_cfg.svh"

module bit_bank
	import huff_pkg::*;
#(
	parameter int BANK_IDX = 0
)(
	input  logic       CLK,
	input  logic       nRST,
	input  pack_req_t  pack_req,
	output bank_bits_t bits
);

	// Absolute buffer index of bit 0 and one past bit 63
	localparam bit_pos_t BASE = bit_pos_t'(BANK_IDX * `HUFF_BANK_BITS);
	localparam bit_pos_t TOP  = bit_pos_t'((BANK_IDX + 1) * `HUFF_BANK_BITS);

	bit_pos_t   req_end;
	logic       in_bank;
	bank_bits_t bits_next;
	bit_pos_t   abs_idx;
	bit_pos_t   offset;
	code_len_t  bit_sel;

	////////////////////////////////////////
	// Range of the request
	////////////////////////////////////////

	assign req_end = pack_req.pos + bit_pos_t'(pack_req.entry.len);

	// Request touches at least one bit of this bank
	assign in_bank = pack_req.valid && (req_end > BASE) && (pack_req.pos < TOP);

	// Each covered bit takes its code bit, MSB first
	always_comb begin
		bits_next = bits;
		abs_idx   = BASE;
		offset    = '0;
		bit_sel   = '0;
		for (int i = 0; i < `HUFF_BANK_BITS; i++) begin
			abs_idx = BASE + bit_pos_t'(i);
			offset  = abs_idx - pack_req.pos;
			bit_sel = code_len_t'(`HUFF_CODE_W - 1) - code_len_t'(offset);
			if (abs_idx >= pack_req.pos && abs_idx < req_end)
				bits_next[i] = pack_req.entry.code[bit_sel];
		end
	end

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			bits <= '0;
		end else if (in_bank) begin
			bits <= bits_next;
		end
	end

	// Requests come from the sequencer and must stay inside the buffer
	a_len_max: assert property (
		@(posedge CLK) disable iff (!nRST)
		pack_req.valid |-> pack_req.entry.len <= code_len_t'(`HUFF_CODE_W)
	);

	a_end_in_buffer: assert property (
		@(posedge CLK) disable iff (!nRST)
		pack_req.valid |-> req_end <= bit_pos_t'(`HUFF_BUF_BITS)
	);

endmodule

// File: src/huff_out_top.sv
`include "huff_cfg.svh"

module huff_out_top
	import huff_pkg::*;
(
	input  logic        CLK,
	input  logic        nRST,
	input  logic        over,
	input  code_table_t code_table,
	output logic        start,
	output out_buf_t    out,
	output bit_pos_t    count
);

	pack_req_t pack_req;

	// Bank b lands at bits 64b+63 down to 64b
	bank_bits_t [`HUFF_NUM_BANKS-1:0] bank_bits;

	////////////////////////////////////////
	// Message walk and code lookup
	////////////////////////////////////////

	symbol_sequencer u_seq (
		.CLK        (CLK),
		.nRST       (nRST),
		.over       (over),
		.code_table (code_table),
		.pack_req   (pack_req),
		.count      (count),
		.start      (start)
	);

	////////////////////////////////////////
	// Buffer slices
	////////////////////////////////////////

	// Same request to every bank, each keeps only its own range
	for (genvar b = 0; b < `HUFF_NUM_BANKS; b++) begin : g_bank
		bit_bank #(
			.BANK_IDX (b)
		) u_bank (
			.CLK      (CLK),
			.nRST     (nRST),
			.pack_req (pack_req),
			.bits     (bank_bits[b])
		);
	end

	assign out = out_buf_t'(bank_bits);

endmodule

// File: sim/huff_ref_model.svh
`ifndef HUFF_REF_MODEL_SVH
`define HUFF_REF_MODEL_SVH

////////////////////////////////////////
// Reference packing model
////////////////////////////////////////

// Symbol n of the message
function automatic sym_t msg_symbol(input int n);
	return sym_t'(n % `HUFF_NUM_SYMBOLS);
endfunction

// Sum of the code lengths over the whole message
function automatic bit_pos_t model_count(input code_table_t tbl);
	int total;
	total = 0;
	for (int n = 0; n < `HUFF_MSG_LEN; n++)
		total += int'(tbl[msg_symbol(n)].len);
	return bit_pos_t'(total);
endfunction

// Appends each code MSB first at the running bit position
function automatic out_buf_t model_buffer(input code_table_t tbl);
	out_buf_t    exp_buf;
	code_entry_t ent;
	int          pos;
	exp_buf = '0;
	pos     = 0;
	for (int n = 0; n < `HUFF_MSG_LEN; n++) begin
		ent = tbl[msg_symbol(n)];
		for (int j = 0; j < int'(ent.len); j++)
			exp_buf[pos + j] = ent.code[`HUFF_CODE_W - 1 - j];
		pos += int'(ent.len);
	end
	return exp_buf;
endfunction

// Random code bits, lengths from one nibble per symbol
function automatic code_table_t random_codes(
	input logic [`HUFF_LEN_W*`HUFF_NUM_SYMBOLS-1:0] lens
);
	code_table_t tbl;
	for (int k = 0; k < `HUFF_NUM_SYMBOLS; k++) begin
		tbl[k].code = code_bits_t'($urandom);
		tbl[k].len  = lens[`HUFF_LEN_W*k +: `HUFF_LEN_W];
	end
	return tbl;
endfunction

`endif

// File: sim/tb_huff_out_top.sv
`include "huff_cfg.svh"

module tb_huff_out_top
	import huff_pkg::*;
();

	localparam int NUM_ROWS = 7;
	localparam int TIMEOUT  = 2000;
	localparam int LATENCY  = 2 * `HUFF_MSG_LEN + 1;

	logic        CLK;
	logic        nRST;
	logic        over;
	code_table_t code_table;
	logic        start;
	out_buf_t    out;
	bit_pos_t    count;

	// Stimulus table, one row per test
	string       row_name  [NUM_ROWS];
	code_table_t row_tbl   [NUM_ROWS];
	logic        row_pause [NUM_ROWS];
	bit_pos_t    row_count [NUM_ROWS];

	int errors;
	int tests_failed;
	int pause_left;

	`include "huff_ref_model.svh"

	huff_out_top dut (
		.CLK        (CLK),
		.nRST       (nRST),
		.over       (over),
		.code_table (code_table),
		.start      (start),
		.out        (out),
		.count      (count)
	);

	always #20 CLK = ~CLK;

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_count(input string name, input bit_pos_t got, input bit_pos_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_buffer(input string name, input out_buf_t got, input out_buf_t exp);
		int low_bad;
		low_bad = -1;
		if (got !== exp) begin
			for (int i = `HUFF_BUF_BITS - 1; i >= 0; i--)
				if (got[i] !== exp[i])
					low_bad = i;
			$display("[FAIL] %s: got %h, expected %h, lowest bad bit %0d",
				name, got, exp, low_bad);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic reset_dut(input code_table_t tbl);
		@(posedge CLK);
		#2;
		nRST       = 1'b0;
		over       = 1'b0;
		code_table = tbl;
		repeat (10) @(posedge CLK);
		#2;
		nRST = 1'b1;
	endtask

	// Random low spans of 1 to 6 cycles on pause rows
	task automatic choose_over(input logic pause);
		if (!pause) begin
			over = 1'b1;
		end else if (pause_left > 0) begin
			over = 1'b0;
			pause_left--;
		end else if ($urandom % 4 == 0) begin
			over       = 1'b0;
			pause_left = int'($urandom % 6);
		end else begin
			over = 1'b1;
		end
	endtask

	task automatic run_row(input int r);
		out_buf_t exp_buf;
		bit_pos_t held;
		logic     over_q;
		int       cycles;
		int       paused;
		int       errors_before;
		errors_before = errors;
		exp_buf       = model_buffer(row_tbl[r]);
		if (model_count(row_tbl[r]) !== row_count[r]) begin
			$display("Row %s: expected count in the table differs from the model", row_name[r]);
			errors++;
		end
		reset_dut(row_tbl[r]);
		@(posedge CLK);
		#2;
		check_flag("start after reset", start, 1'b0);
		check_count("count after reset", count, '0);
		check_buffer("out after reset", out, '0);

		pause_left = 0;
		over       = 1'b1;
		held       = count;
		cycles     = 0;
		paused     = 0;
		while (start !== 1'b1 && cycles < TIMEOUT) begin
			@(posedge CLK);
			over_q = over;
			#2;
			cycles++;
			if (!over_q) begin
				paused++;
				check_count("count while paused", count, held);
			end
			held = count;
			choose_over(row_pause[r]);
		end

		if (start !== 1'b1) begin
			$display("Row %s: start did not rise within %0d cycles", row_name[r], TIMEOUT);
			errors++;
		end else begin
			// First edge with over high counts as cycle zero
			if (!row_pause[r])
				check_latency("start latency", cycles - 1, LATENCY);
			else if (paused == 0) begin
				$display("Row %s: over was never low before start rose", row_name[r]);
				errors++;
			end
			check_count("count", count, row_count[r]);
			check_buffer("out", out, exp_buf);
			repeat (8) begin
				@(posedge CLK);
				#2;
				check_flag("start held", start, 1'b1);
				check_count("count held", count, row_count[r]);
				choose_over(row_pause[r]);
			end
			check_buffer("out held", out, exp_buf);
		end
		over = 1'b0;

		if (errors == errors_before) begin
			$display("Test %0d %s: ok", r, row_name[r]);
		end else begin
			$display("Test %0d %s: %0d errors", r, row_name[r], errors - errors_before);
			tests_failed++;
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(32'hd74f00a0));
		CLK          = 1'b0;
		nRST         = 1'b0;
		over         = 1'b0;
		code_table   = '0;
		errors       = 0;
		tests_failed = 0;
		pause_left   = 0;

		// Length nibbles, symbol 0 in the rightmost digit
		row_name[0] = "all_len9";
		row_tbl[0]  = random_codes(40'h9999999999);
		row_name[1] = "ascending_len";
		row_tbl[1]  = random_codes(40'h9876543210);
		row_name[2] = "mixed_len";
		row_tbl[2]  = random_codes(40'h7182059703);
		row_name[3] = "all_len7";
		row_tbl[3]  = random_codes(40'h7777777777);
		row_name[4] = "all_len0";
		row_tbl[4]  = random_codes(40'h0000000000);
		row_name[5] = "pause_len9";
		row_tbl[5]  = row_tbl[0];
		row_name[6] = "pause_mixed";
		row_tbl[6]  = row_tbl[2];
		row_pause = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
		row_count = '{11'd1008, 11'd496, 11'd465, 11'd784, 11'd0, 11'd1008, 11'd465};

		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d failed checks",
			NUM_ROWS, NUM_ROWS - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+src
+incdir+sim
src/huff_pkg.sv
src/symbol_sequencer.sv
src/bit_bank.sv
src/huff_out_top.sv
sim/tb_huff_out_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

TOP=tb_huff_out_top
BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "${BUILD_DIR}" "${LOG}"

verilator --binary --timing --assert \
	-Wno-fatal \
	--top-module "${TOP}" \
	--Mdir "${BUILD_DIR}" \
	-f filelist.f

"./${BUILD_DIR}/V${TOP}" > "${LOG}" 2>&1
cat "${LOG}"

if grep -qF "*** TEST PASSED ***" "${LOG}"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see ${LOG}"
	exit 1
fi
